// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////
    // widths
    localparam int word_w   = 16;
    localparam int reg_w    = 2;
    localparam int op_w     = 4;
    localparam int fn_w     = 6;
    localparam int imm_w    = 8;
    localparam int num_regs = 1 << reg_w;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_w-1:0]  reg_idx_t;
    typedef logic [op_w-1:0]   opcode_t;
    typedef logic [fn_w-1:0]   funct_t;
    typedef logic [imm_w-1:0]  imm_t;
    typedef logic [1:0]        fwd_sel_t;
    typedef logic [1:0]        alu_op_t;

    localparam fwd_sel_t fwd_none = 2'd0;  // register read
    localparam fwd_sel_t fwd_mem  = 2'd1;  // ex/mem alu result
    localparam fwd_sel_t fwd_wb   = 2'd2;  // write-back value

    localparam alu_op_t alu_add = 2'd0;
    localparam alu_op_t alu_sub = 2'd1;
    localparam alu_op_t alu_and = 2'd2;
    localparam alu_op_t alu_or  = 2'd3;

    ////////////////////////////////////////
    // instruction layout
    localparam int op_lo = 12;
    localparam int rs_lo = 10;
    localparam int rt_lo = 8;
    localparam int rd_lo = 6;

    localparam opcode_t op_rtype = 4'd15;
    localparam opcode_t op_adi   = 4'd4;
    localparam opcode_t op_lwd   = 4'd7;
    localparam opcode_t op_swd   = 4'd8;

    localparam funct_t fn_add = 6'd0;
    localparam funct_t fn_sub = 6'd1;
    localparam funct_t fn_and = 6'd2;
    localparam funct_t fn_orr = 6'd3;
    localparam funct_t fn_wwd = 6'd28;
    localparam funct_t fn_hlt = 6'd29;

    localparam word_t nop_inst = 16'h0000;  // unused opcode, no side effects

    function automatic opcode_t inst_opcode(word_t inst);
        return inst[op_lo +: op_w];
    endfunction

    function automatic reg_idx_t inst_rs(word_t inst);
        return inst[rs_lo +: reg_w];
    endfunction

    function automatic reg_idx_t inst_rt(word_t inst);
        return inst[rt_lo +: reg_w];
    endfunction

    function automatic reg_idx_t inst_rd(word_t inst);
        return inst[rd_lo +: reg_w];
    endfunction

    function automatic funct_t inst_funct(word_t inst);
        return inst[fn_w-1:0];
    endfunction

    function automatic imm_t inst_imm(word_t inst);
        return inst[imm_w-1:0];
    endfunction

    ////////////////////////////////////////
    // pipeline registers
    typedef struct packed {
        logic    valid;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    wwd;
        logic    halt;
        logic    alu_src;   // b operand from immediate
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        word_t    a;
        word_t    b;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    alu_result;
        word_t    store_data;
        word_t    wwd_value;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    alu_result;
        word_t    load_data;
        word_t    wwd_value;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           stall,
    input  logic           halt_seen,
    input  cpu_pkg::word_t data1,
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    output cpu_pkg::word_t if_inst,
    output logic           if_valid
);
    import cpu_pkg::*;

    word_t pc;
    logic  frozen;  // set once HLT leaves ID

    assign read_m1  = ~(frozen | halt_seen);
    assign address1 = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc       <= '0;
            frozen   <= 1'b0;
            if_valid <= 1'b0;
            if_inst  <= nop_inst;
        end else if (!stall) begin  // stall holds pc and if/id
            if (halt_seen || frozen) begin
                frozen   <= 1'b1;
                if_valid <= 1'b0;
                if_inst  <= nop_inst;
            end else begin
                pc       <= pc + word_t'(1);
                if_valid <= 1'b1;
                if_inst  <= data1;
            end
        end
    end

    pc_held_on_stall: assert property (@(posedge clk) disable iff (reset_n)
        stall |=> $stable(pc));

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              stall,
    input  cpu_pkg::word_t    if_inst,
    input  logic              if_valid,
    input  cpu_pkg::word_t    read_a,
    input  cpu_pkg::word_t    read_b,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rt,
    output logic              halt_seen,
    output cpu_pkg::id_ex_t   id_ex
);
    import cpu_pkg::*;

    opcode_t  op;
    funct_t   fn;
    imm_t     imm;
    word_t    imm_ext;
    ctrl_t    ctrl;
    reg_idx_t dest;

    assign op  = inst_opcode(if_inst);
    assign fn  = inst_funct(if_inst);
    assign imm = inst_imm(if_inst);
    assign rs  = inst_rs(if_inst);
    assign rt  = inst_rt(if_inst);

    assign imm_ext = {{(word_w - imm_w){imm[imm_w-1]}}, imm};

    always_comb begin
        ctrl = '0;
        dest = inst_rd(if_inst);
        if (if_valid) begin
            ctrl.valid = 1'b1;  // unknown opcodes still retire
            case (op)
                op_rtype: begin
                    case (fn)
                        fn_add: begin
                            ctrl.reg_write = 1'b1;
                            ctrl.alu_op    = alu_add;
                        end
                        fn_sub: begin
                            ctrl.reg_write = 1'b1;
                            ctrl.alu_op    = alu_sub;
                        end
                        fn_and: begin
                            ctrl.reg_write = 1'b1;
                            ctrl.alu_op    = alu_and;
                        end
                        fn_orr: begin
                            ctrl.reg_write = 1'b1;
                            ctrl.alu_op    = alu_or;
                        end
                        fn_wwd:  ctrl.wwd  = 1'b1;
                        fn_hlt:  ctrl.halt = 1'b1;
                        default: ;
                    endcase
                end
                op_adi: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    dest           = rt;
                end
                op_lwd: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    dest           = rt;
                end
                op_swd: begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;  // base + offset
                end
                default: ;
            endcase
        end
    end

    assign halt_seen = ctrl.halt;

    ////////////////////////////////////////
    // id/ex register
    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= stall ? ctrl_t'('0) : ctrl;  // bubble on load-use
        end
        id_ex.rs   <= rs;
        id_ex.rt   <= rt;
        id_ex.dest <= dest;
        id_ex.a    <= read_a;
        id_ex.b    <= read_b;
        id_ex.imm  <= imm_ext;
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    input  cpu_pkg::reg_idx_t wb_dest,
    input  cpu_pkg::word_t    wb_value,
    input  logic              wb_write,
    output cpu_pkg::word_t    read_a,
    output cpu_pkg::word_t    read_b
);
    import cpu_pkg::*;

    word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_dest] <= wb_value;
        end
    end

    // write-through so ID sees the value retiring this cycle
    assign read_a = (wb_write && wb_dest == rs) ? wb_value : regs[rs];
    assign read_b = (wb_write && wb_dest == rt) ? wb_value : regs[rt];

    // mem/wb is cleared by the first reset edge
    no_write_in_reset: assert property (@(posedge clk)
        reset_n && $past(reset_n) |-> !wb_write);

endmodule

`default_nettype wire

// ==== hazard_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_forward (
    input  cpu_pkg::word_t    if_inst,
    input  logic              if_valid,
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  cpu_pkg::mem_wb_t  mem_wb,
    output logic              stall,
    output cpu_pkg::fwd_sel_t fwd_a,
    output cpu_pkg::fwd_sel_t fwd_b
);
    import cpu_pkg::*;

    opcode_t op;
    logic    uses_rs;
    logic    uses_rt;

    function automatic fwd_sel_t pick(reg_idx_t src, ex_mem_t em, mem_wb_t mw);
        if (em.ctrl.valid && em.ctrl.reg_write && em.dest == src) begin
            return fwd_mem;  // youngest writer first
        end else if (mw.ctrl.valid && mw.ctrl.reg_write && mw.dest == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign op      = inst_opcode(if_inst);
    assign uses_rs = (op == op_rtype) || (op == op_adi) || (op == op_lwd) || (op == op_swd);
    assign uses_rt = (op == op_rtype) || (op == op_swd);

    // load in EX feeding the instruction in ID
    assign stall = if_valid && id_ex.ctrl.mem_read &&
                   ((uses_rs && id_ex.dest == inst_rs(if_inst)) ||
                    (uses_rt && id_ex.dest == inst_rt(if_inst)));

    assign fwd_a = pick(id_ex.rs, ex_mem, mem_wb);
    assign fwd_b = pick(id_ex.rt, ex_mem, mem_wb);

    // mem_read only reaches ID/EX with valid set
    always_comb begin
        if (stall) begin
            stall_needs_load: assert (id_ex.ctrl.valid);
        end
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::word_t    wb_value,
    output cpu_pkg::ex_mem_t  ex_mem
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_y;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, id_ex.a, ex_mem.alu_result, wb_value);
    assign op_b  = fwd_mux(fwd_b, id_ex.b, ex_mem.alu_result, wb_value);
    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

    ////////////////////////////////////////
    // alu
    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub: alu_y = op_a - alu_b;
            alu_and: alu_y = op_a & alu_b;
            alu_or:  alu_y = op_a | alu_b;
            default: alu_y = op_a + alu_b;  // add, adi, address calc
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
        ex_mem.dest       <= id_ex.dest;
        ex_mem.alu_result <= alu_y;
        ex_mem.store_data <= op_b;  // swd writes rt
        ex_mem.wwd_value  <= op_a;  // wwd outputs rs
    end

endmodule

`default_nettype wire

// ==== memory_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  cpu_pkg::word_t    read_data2,
    output logic              read_m2,
    output logic              write_m2,
    output cpu_pkg::word_t    address2,
    output cpu_pkg::word_t    write_data2,
    output cpu_pkg::mem_wb_t  mem_wb,
    output cpu_pkg::reg_idx_t wb_dest,
    output cpu_pkg::word_t    wb_value,
    output logic              wb_write,
    output cpu_pkg::word_t    num_inst,
    output cpu_pkg::word_t    output_port,
    output logic              is_halted
);
    import cpu_pkg::*;

    // data port, same-cycle read data
    assign read_m2     = ex_mem.ctrl.valid & ex_mem.ctrl.mem_read;
    assign write_m2    = ex_mem.ctrl.valid & ex_mem.ctrl.mem_write;
    assign address2    = ex_mem.alu_result;
    assign write_data2 = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_wb.ctrl <= '0;
        end else begin
            mem_wb.ctrl <= ex_mem.ctrl;
        end
        mem_wb.dest       <= ex_mem.dest;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.load_data  <= read_data2;
        mem_wb.wwd_value  <= ex_mem.wwd_value;
    end

    ////////////////////////////////////////
    // write-back
    assign wb_dest  = mem_wb.dest;
    assign wb_value = mem_wb.ctrl.mem_read ? mem_wb.load_data : mem_wb.alu_result;
    assign wb_write = mem_wb.ctrl.valid & mem_wb.ctrl.reg_write;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else if (mem_wb.ctrl.valid) begin
            num_inst <= num_inst + word_t'(1);
            if (mem_wb.ctrl.wwd) begin
                output_port <= mem_wb.wwd_value;
            end
            if (mem_wb.ctrl.halt) begin
                is_halted <= 1'b1;  // sticky until reset
            end
        end
    end

    one_data_strobe: assert property (@(posedge clk) disable iff (reset_n)
        !(read_m2 && write_m2));

endmodule

`default_nettype wire

// ==== cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic           clk,
    input  logic           reset_n,
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    input  cpu_pkg::word_t data1,
    output logic           read_m2,
    output logic           write_m2,
    output cpu_pkg::word_t address2,
    output cpu_pkg::word_t write_data2,
    input  cpu_pkg::word_t read_data2,
    output cpu_pkg::word_t num_inst,
    output cpu_pkg::word_t output_port,
    output logic           is_halted
);
    import cpu_pkg::*;

    // if/id
    word_t    if_inst;
    logic     if_valid;
    logic     stall;
    logic     halt_seen;

    // id
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    read_a;
    word_t    read_b;

    // pipeline registers
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    // write-back
    reg_idx_t wb_dest;
    word_t    wb_value;
    logic     wb_write;

    fetch_stage fetch_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .stall     (stall),
        .halt_seen (halt_seen),
        .data1     (data1),
        .read_m1   (read_m1),
        .address1  (address1),
        .if_inst   (if_inst),
        .if_valid  (if_valid)
    );

    decode_stage decode_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .stall     (stall),
        .if_inst   (if_inst),
        .if_valid  (if_valid),
        .read_a    (read_a),
        .read_b    (read_b),
        .rs        (rs),
        .rt        (rt),
        .halt_seen (halt_seen),
        .id_ex     (id_ex)
    );

    register_file regs_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .rs       (rs),
        .rt       (rt),
        .wb_dest  (wb_dest),
        .wb_value (wb_value),
        .wb_write (wb_write),
        .read_a   (read_a),
        .read_b   (read_b)
    );

    hazard_forward hazard_i (
        .if_inst  (if_inst),
        .if_valid (if_valid),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .stall    (stall),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

    execute_stage execute_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .id_ex    (id_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .wb_value (wb_value),
        .ex_mem   (ex_mem)
    );

    memory_writeback mem_wb_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .ex_mem      (ex_mem),
        .read_data2  (read_data2),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .write_data2 (write_data2),
        .mem_wb      (mem_wb),
        .wb_dest     (wb_dest),
        .wb_value    (wb_value),
        .wb_write    (wb_write),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

endmodule

`default_nettype wire

// ==== cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int num_progs   = 20;
    localparam int prog_len    = 39;  // random part, HLT follows
    localparam int cycle_limit = num_progs * ((prog_len + 1) * 2 + 20);

    logic  clk = 1'b0;
    logic  reset_n;
    logic  read_m1;
    word_t address1;
    word_t data1;
    logic  read_m2;
    logic  write_m2;
    word_t address2;
    word_t write_data2;
    word_t read_data2;
    word_t num_inst;
    word_t output_port;
    logic  is_halted;

    logic [31:0] lcg_state = 32'hd81fb27a;
    int          cycle_count = 0;
    int          prog;
    logic        checking;
    word_t       last_out;

    word_t imem [64];
    word_t dmem [16];   // words 64..79

    // reference model state
    word_t m_regs [num_regs];
    word_t m_dmem [16];
    word_t exp_wwd [$];
    word_t exp_st_addr [$];
    word_t exp_st_data [$];
    word_t exp_ld_addr [$];
    int    exp_count;

    cpu cpu_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .write_data2 (write_data2),
        .read_data2  (read_data2),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles in program %0d", cycle_count, prog));
        end
    end

    ////////////////////////////////////////
    // reporting

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(int n);
        return int'(next_random() >> 8) % n;
    endfunction

    function automatic word_t fill_word(word_t addr);
        return (addr ^ 16'h0033) + {addr[15:8], addr[15:8]};
    endfunction

    function automatic word_t inst_at(word_t addr);
        if (addr < 16'd64) begin
            return imem[addr[5:0]];
        end
        return nop_inst;  // past the program
    endfunction

    function automatic logic in_window(word_t addr);
        return addr >= 16'd64 && addr < 16'd80;
    endfunction

    function automatic word_t data_at(word_t addr);
        if (in_window(addr)) begin
            return dmem[addr[3:0]];
        end
        return fill_word(addr);
    endfunction

    function automatic word_t enc_r(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic funct_t alu_funct(int i);
        case (i)
            0:       return fn_add;
            1:       return fn_sub;
            2:       return fn_and;
            default: return fn_orr;
        endcase
    endfunction

    // half the time reuse the last written register
    function automatic reg_idx_t pick_src(reg_idx_t last);
        if (random_below(2) == 0) begin
            return last;
        end
        return reg_idx_t'(random_below(4));
    endfunction

    ////////////////////////////////////////
    // instruction-level reference model

    task automatic model_exec(word_t inst);
        opcode_t  op;
        funct_t   fn;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    sext;
        op   = inst[15:12];
        fn   = inst[5:0];
        rs   = inst[11:10];
        rt   = inst[9:8];
        rd   = inst[7:6];
        a    = m_regs[rs];
        b    = m_regs[rt];
        sext = {{8{inst[7]}}, inst[7:0]};
        case (op)
            op_rtype: begin
                case (fn)
                    fn_add:  m_regs[rd] = a + b;
                    fn_sub:  m_regs[rd] = a - b;
                    fn_and:  m_regs[rd] = a & b;
                    fn_orr:  m_regs[rd] = a | b;
                    fn_wwd:  exp_wwd.push_back(a);
                    default: ;
                endcase
            end
            op_adi: m_regs[rt] = a + sext;
            op_lwd: begin
                exp_ld_addr.push_back(a + sext);
                m_regs[rt] = in_window(a + sext) ? m_dmem[4'(a + sext)] : fill_word(a + sext);
            end
            op_swd: begin
                exp_st_addr.push_back(a + sext);
                exp_st_data.push_back(b);
                if (in_window(a + sext)) begin
                    m_dmem[4'(a + sext)] = b;
                end
            end
            default: ;
        endcase
        exp_count++;
    endtask

    // program generation runs the model in step, so loads and stores can aim at 64..79
    task automatic gen_program();
        reg_idx_t last_dest;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        reg_idx_t base;
        int       kind;
        logic     found;
        word_t    inst;
        word_t    target;
        word_t    diff;
        last_dest = '0;
        exp_wwd.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        exp_ld_addr.delete();
        exp_count = 0;
        for (int i = 0; i < num_regs; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            m_dmem[i] = fill_word(word_t'(64 + i));
        end
        for (int i = 0; i < 64; i++) begin
            imem[i] = nop_inst;
        end
        for (int k = 0; k < prog_len; k++) begin
            rs   = pick_src(last_dest);
            rt   = pick_src(last_dest);
            rd   = reg_idx_t'(random_below(4));
            kind = random_below(16);
            inst = nop_inst;
            if (kind < 6) begin
                inst = enc_r(alu_funct(random_below(4)), rs, rt, rd);
            end else if (kind < 8) begin
                inst = enc_i(op_adi, rs, rt, imm_t'(random_below(256)));
            end else if (kind < 13) begin
                target = word_t'(64 + random_below(16));
                found  = 1'b0;
                for (int j = 0; j < 4; j++) begin
                    base = rs + reg_idx_t'(j);
                    diff = target - m_regs[base];
                    if (!found && (diff <= 16'd127 || diff >= 16'hff80)) begin
                        found = 1'b1;
                        inst  = enc_i(kind < 11 ? op_lwd : op_swd, base, rt, diff[7:0]);
                    end
                end
                if (!found) begin
                    inst = enc_r(fn_sub, rs, rs, rs);  // zero a base register
                end
            end else begin
                inst = enc_r(fn_wwd, rs, rt, rd);
            end
            imem[k] = inst;
            model_exec(inst);
            last_dest = (inst[15:12] == op_rtype) ? inst[7:6] : inst[9:8];
        end
        imem[prog_len] = enc_r(fn_hlt, 2'd0, 2'd0, 2'd0);
        model_exec(imem[prog_len]);
    endtask

    ////////////////////////////////////////
    // per-cycle memory service and port checks

    task automatic check_output();
        word_t expected;
        check_bit($sformatf("prog %0d output change while halted", prog), 1'b0, is_halted);
        while (exp_wwd.size() > 0 && exp_wwd[0] == last_out) begin
            exp_wwd.delete(0);  // rewrite of the same value is invisible
        end
        if (exp_wwd.size() == 0) begin
            fail_run($sformatf("program %0d changed output_port with no WWD left", prog));
        end else begin
            expected = exp_wwd.pop_front();
            check_word($sformatf("prog %0d output_port", prog), expected, output_port);
            last_out = output_port;
        end
    endtask

    task automatic step_cycle();
        word_t exp_addr;
        word_t exp_data;
        @(negedge clk);
        if (checking && read_m2 === 1'b1) begin
            if (exp_ld_addr.size() == 0) begin
                fail_run($sformatf("program %0d made a load the model does not have", prog));
            end else begin
                exp_addr = exp_ld_addr.pop_front();
                check_word($sformatf("prog %0d load address", prog), exp_addr, address2);
            end
        end
        if (checking && write_m2 === 1'b1) begin
            check_bit($sformatf("prog %0d store while halted", prog), 1'b0, is_halted);
            if (exp_st_addr.size() == 0) begin
                fail_run($sformatf("program %0d made a store the model does not have", prog));
            end else begin
                exp_addr = exp_st_addr.pop_front();
                exp_data = exp_st_data.pop_front();
                check_word($sformatf("prog %0d store address", prog), exp_addr, address2);
                check_word($sformatf("prog %0d store data", prog), exp_data, write_data2);
                if (in_window(address2)) begin
                    dmem[address2[3:0]] = write_data2;
                end
            end
        end
        if (checking && output_port !== last_out) begin
            check_output();
        end
        data1      = read_m1 ? inst_at(address1) : nop_inst;  // no fetch without read_m1
        read_data2 = data_at(address2);
    endtask

    task automatic run_program();
        checking = 1'b0;
        gen_program();
        for (int i = 0; i < 16; i++) begin
            dmem[i] = fill_word(word_t'(64 + i));
        end
        reset_n = 1'b1;
        step_cycle();
        last_out = '0;
        checking = 1'b1;
        repeat (2) step_cycle();
        check_word($sformatf("prog %0d num_inst after reset", prog), '0, num_inst);
        check_word($sformatf("prog %0d output_port after reset", prog), '0, output_port);
        check_bit($sformatf("prog %0d is_halted after reset", prog), 1'b0, is_halted);
        check_bit($sformatf("prog %0d read_m2 after reset", prog), 1'b0, read_m2);
        check_bit($sformatf("prog %0d write_m2 after reset", prog), 1'b0, write_m2);
        reset_n = 1'b0;
        while (is_halted !== 1'b1) begin
            step_cycle();
        end
        check_word($sformatf("prog %0d num_inst at halt", prog), word_t'(exp_count), num_inst);
        repeat (10) begin
            step_cycle();
            check_bit($sformatf("prog %0d is_halted held", prog), 1'b1, is_halted);
            check_bit($sformatf("prog %0d read_m1 after halt", prog), 1'b0, read_m1);
        end
        while (exp_wwd.size() > 0 && exp_wwd[0] == last_out) begin
            exp_wwd.delete(0);
        end
        check_word($sformatf("prog %0d WWD values not seen", prog), '0, word_t'(exp_wwd.size()));
        check_word($sformatf("prog %0d stores not seen", prog), '0, word_t'(exp_st_addr.size()));
        check_word($sformatf("prog %0d loads not seen", prog), '0, word_t'(exp_ld_addr.size()));
    endtask

    initial begin
        reset_n    = 1'b1;
        data1      = nop_inst;
        read_data2 = '0;
        checking   = 1'b0;
        last_out   = '0;
        for (prog = 0; prog < num_progs; prog++) begin
            run_program();
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu.f ====
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
hazard_forward.sv
execute_stage.sv
memory_writeback.sv
cpu.sv
cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module cpu_tb -f cpu.f -o cpu_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "FAIL: build error"
    exit 1
fi

./obj_dir/cpu_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Something failed" "$sim_log"; then
    echo "FAIL: testbench reported an error"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "FAIL: simulator exited with status $sim_status"
    exit 1
fi
echo "PASS"
exit 0
